//--- bt_link_pkg.sv
// frame, FIFO and sensor constants plus the controller state encoding
// FIFO_DEPTH must stay a power of two because the FIFO pointers wrap by overflow
// a serial character is one start bit, WORD_W data bits sent lsb first, one stop bit
package bt_link_pkg;

	localparam int WORD_W = 16;
	localparam int BIT_CYCLES = 8; // clocks per serial bit
	localparam int FRAME_BITS = WORD_W + 2;
	localparam int CYC_W = $clog2(BIT_CYCLES);
	localparam int BIT_IDX_W = $clog2(FRAME_BITS);

	localparam int FIFO_DEPTH = 16;
	localparam int COUNT_W = 5;
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	localparam int SENSOR_BURST = 10; // samples per data-mode connection
	localparam logic [WORD_W-1:0] SENSOR_BASE = 16'h5A00;
	localparam logic [WORD_W-1:0] AT_END = 16'h0D0A; // cr then lf

	typedef enum logic [3:0] {
		idle             = 4'h0,
		wait_user_data   = 4'h1,
		load_t_user      = 4'h2,
		rest_t_user      = 4'h3,
		load_t_sample    = 4'h4,
		rest_t_sample    = 4'h5,
		load_tx          = 4'h6,
		begin_tx         = 4'h7,
		rest_tx          = 4'h8,
		receive_resp     = 4'h9,
		load_resp        = 4'ha,
		rest_resp        = 4'hb,
		wait_user_demand = 4'hc,
		read_resp        = 4'hd,
		rest_resp_user   = 4'he,
		done             = 4'hf
	} link_state_t;

endpackage

//--- bt_host_pkg.sv
// host side command bits and status word
// command bits are plain levels, the host changes one only after the state shows
// status carries fill counts and done pulses in place of debug mirror words
package bt_host_pkg;

	typedef struct packed {
		logic want_at; // command mode when high
		logic begin_connection;
		logic user_data_loaded;
		logic user_data_done;
		logic resp_access;
		logic resp_finished;
	} host_cmd_t;

	typedef struct packed {
		bt_link_pkg::link_state_t state;
		logic [bt_link_pkg::COUNT_W-1:0] tx_count;
		logic [bt_link_pkg::COUNT_W-1:0] resp_count;
		logic tx_full;
		logic tx_empty;
		logic resp_full;
		logic resp_empty;
		logic tx_done;
		logic rx_done;
	} link_status_t;

endpackage

//--- word_fifo.sv
`timescale 1ns/10ps
// single clock word FIFO
// a read puts the head word on dout one clock later, dout then holds until the next read
// a write when full or a read when empty is dropped without any flag
// dout is unknown until the first read after power up
module word_fifo (
	input  logic clock,
	input  logic reset,
	input  logic wr,
	input  logic rd,
	input  logic [bt_link_pkg::WORD_W-1:0] din,
	output logic [bt_link_pkg::WORD_W-1:0] dout,
	output logic full,
	output logic empty,
	output logic [bt_link_pkg::COUNT_W-1:0] count
);
	import bt_link_pkg::*;

	logic [WORD_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign full = (count == COUNT_W'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1; // wraps at FIFO_DEPTH
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (do_wr)
			mem[wr_ptr] <= din;
		if (do_rd)
			dout <= mem[rd_ptr];
	end

endmodule

//--- word_serializer.sv
`timescale 1ns/10ps
// sends one word as start bit, data lsb first, stop bit, BIT_CYCLES clocks per bit
// the word is taken on the first clock that sees start while idle
// tx_done marks the last clock of the stop bit, 18 bit times after that first clock
module word_serializer (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  logic [bt_link_pkg::WORD_W-1:0] word,
	output logic tx_done,
	output logic txd
);
	import bt_link_pkg::*;

	logic busy;
	logic [FRAME_BITS-1:0] shift; // stop, data, start
	logic [BIT_IDX_W-1:0] bit_idx;
	logic [CYC_W-1:0] cyc_cnt;
	logic last_cycle;

	assign last_cycle = (cyc_cnt == CYC_W'(BIT_CYCLES - 1));
	assign tx_done = busy && last_cycle && (bit_idx == BIT_IDX_W'(FRAME_BITS - 1));
	assign txd = busy ? shift[0] : 1'b1; // line idles high

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			bit_idx <= '0;
			cyc_cnt <= '0;
		end
		else if (!busy)
		begin
			if (start)
			begin
				busy <= 1'b1;
				bit_idx <= '0;
				cyc_cnt <= '0;
			end
		end
		else if (last_cycle)
		begin
			cyc_cnt <= '0;
			if (bit_idx == BIT_IDX_W'(FRAME_BITS - 1))
				busy <= 1'b0;
			else
				bit_idx <= bit_idx + 1'b1;
		end
		else
			cyc_cnt <= cyc_cnt + 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (!busy && start)
			shift <= {1'b1, word, 1'b0};
		else if (busy && last_cycle)
			shift <= {1'b1, shift[FRAME_BITS-1:1]};
	end

endmodule

//--- word_deserializer.sv
`timescale 1ns/10ps
// receives one framed character at BIT_CYCLES clocks per bit
// a falling edge is only taken while arm is high, a running frame finishes regardless
// a start bit that is high at mid-bit drops the frame, the stop bit is not checked
// rx_word holds from the rx_done pulse until the next frame completes
module word_deserializer (
	input  logic clock,
	input  logic reset,
	input  logic arm,
	input  logic rxd,
	output logic rx_done,
	output logic [bt_link_pkg::WORD_W-1:0] rx_word
);
	import bt_link_pkg::*;

	logic [1:0] rxd_sync;
	logic rxd_prev;
	logic line;
	logic fall;
	logic busy;
	logic [BIT_IDX_W-1:0] bit_idx; // 0 start, 1..16 data, 17 stop
	logic [CYC_W-1:0] cyc_cnt;
	logic sample_now;
	logic [WORD_W-1:0] shift;

	assign line = rxd_sync[1];
	assign fall = rxd_prev && !line;
	assign sample_now = busy && (cyc_cnt == CYC_W'(BIT_CYCLES - 1));

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rxd_sync <= 2'b11;
			rxd_prev <= 1'b1;
			busy <= 1'b0;
			bit_idx <= '0;
			cyc_cnt <= '0;
			rx_done <= 1'b0;
		end
		else
		begin
			rxd_sync <= {rxd_sync[0], rxd};
			rxd_prev <= line;
			rx_done <= 1'b0;
			if (!busy)
			begin
				if (arm && fall)
				begin
					busy <= 1'b1;
					bit_idx <= '0;
					cyc_cnt <= CYC_W'(BIT_CYCLES / 2); // first sample lands mid start bit
				end
			end
			else if (sample_now)
			begin
				cyc_cnt <= '0;
				if (bit_idx == '0 && line)
					busy <= 1'b0; // glitch, not a start bit
				else if (bit_idx == BIT_IDX_W'(FRAME_BITS - 1))
				begin
					busy <= 1'b0;
					rx_done <= 1'b1;
				end
				else
					bit_idx <= bit_idx + 1'b1;
			end
			else
				cyc_cnt <= cyc_cnt + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (sample_now && bit_idx != '0 && bit_idx != BIT_IDX_W'(FRAME_BITS - 1))
			shift <= {line, shift[WORD_W-1:1]}; // lsb arrives first
		if (sample_now && bit_idx == BIT_IDX_W'(FRAME_BITS - 1))
			rx_word <= shift;
	end

endmodule

//--- sample_source.sv
`timescale 1ns/10ps
// stand-in sensor, gives SENSOR_BASE plus a wrapping index
// the index only moves on next and survives between connections
module sample_source (
	input  logic clock,
	input  logic reset,
	input  logic next,
	output logic [bt_link_pkg::WORD_W-1:0] sample
);
	import bt_link_pkg::*;

	logic [WORD_W-1:0] index;

	assign sample = SENSOR_BASE + index;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			index <= '0;
		else if (next)
			index <= index + 1'b1;
	end

endmodule

//--- bt_link_ctrl.sv
`timescale 1ns/10ps
// connection FSM for the radio link with every strobe decoded from the current state
// there is no back-pressure, so the host loads at most FIFO_DEPTH words and waits
// for the state to show before it changes a command bit
// a reply ends only on AT_END and a lost terminator keeps the FSM in receive_resp
module bt_link_ctrl (
	input  logic clock,
	input  logic reset,
	input  bt_host_pkg::host_cmd_t cmd,
	input  logic [bt_link_pkg::COUNT_W-1:0] tx_count,
	input  logic tx_empty,
	input  logic tx_done,
	input  logic rx_done,
	input  logic [bt_link_pkg::WORD_W-1:0] rx_word,
	output bt_link_pkg::link_state_t state,
	output logic tx_wr,
	output logic tx_rd,
	output logic tx_start,
	output logic sample_next,
	output logic rx_arm,
	output logic resp_wr,
	output logic resp_rd,
	output logic bt_enable
);
	import bt_link_pkg::*;

	link_state_t next_state;
	logic [WORD_W-1:0] last_word; // last reply word stored

	assign tx_wr = (state == load_t_user) || (state == load_t_sample);
	assign sample_next = (state == load_t_sample);
	assign tx_rd = (state == load_tx);
	assign tx_start = (state == begin_tx);
	assign rx_arm = (state == receive_resp);
	assign resp_wr = (state == load_resp);
	assign resp_rd = (state == read_resp);
	assign bt_enable = ~cmd.want_at; // radio in data mode

	always_comb
	begin
		next_state = state;
		case (state)
			idle:
				if (cmd.begin_connection)
					next_state = cmd.want_at ? wait_user_data : load_t_sample;
			wait_user_data:
				if (cmd.user_data_loaded)
					next_state = load_t_user;
			load_t_user:
				next_state = rest_t_user;
			rest_t_user:
				next_state = cmd.user_data_done ? load_tx : wait_user_data;
			load_t_sample:
				next_state = rest_t_sample;
			rest_t_sample:
				if (tx_count == COUNT_W'(SENSOR_BURST))
					next_state = load_tx;
				else
					next_state = load_t_sample;
			load_tx:
				next_state = begin_tx;
			begin_tx:
				if (tx_done)
					next_state = rest_tx;
			rest_tx:
				if (!tx_empty)
					next_state = load_tx;
				else
					next_state = cmd.want_at ? receive_resp : done; // no reply in data mode
			receive_resp:
				if (rx_done)
					next_state = load_resp;
			load_resp:
				next_state = rest_resp;
			rest_resp:
				next_state = (last_word == AT_END) ? wait_user_demand : receive_resp;
			wait_user_demand:
				if (cmd.resp_access)
					next_state = read_resp;
			read_resp:
				next_state = rest_resp_user;
			rest_resp_user:
				next_state = cmd.resp_finished ? done : wait_user_demand;
			done:
				if (!cmd.begin_connection)
					next_state = idle;
			default:
				next_state = idle;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= idle;
		else
			state <= next_state;
	end

	always_ff @(posedge clock)
	begin
		if (resp_wr)
			last_word <= rx_word;
	end

endmodule

//--- bt_link_top.sv
`timescale 1ns/10ps
// radio link controller top, host on plain ports and one clock throughout
// the transmit FIFO takes host_word in command mode and the sensor sample otherwise
// resp_word is valid from rest_resp_user until the next read
module bt_link_top (
	input  logic clock,
	input  logic reset,
	input  bt_host_pkg::host_cmd_t cmd,
	input  logic [bt_link_pkg::WORD_W-1:0] host_word,
	input  logic rxd,
	output logic txd,
	output logic bt_enable,
	output bt_host_pkg::link_status_t status,
	output logic [bt_link_pkg::WORD_W-1:0] resp_word
);
	import bt_link_pkg::*;

	link_state_t state;
	logic [WORD_W-1:0] sample;
	logic [WORD_W-1:0] tx_din;
	logic [WORD_W-1:0] tx_dout;
	logic [WORD_W-1:0] rx_word;
	logic [COUNT_W-1:0] tx_count;
	logic [COUNT_W-1:0] resp_count;
	logic tx_full;
	logic tx_empty;
	logic resp_full;
	logic resp_empty;
	logic tx_wr;
	logic tx_rd;
	logic tx_start;
	logic tx_done;
	logic sample_next;
	logic rx_arm;
	logic rx_done;
	logic resp_wr;
	logic resp_rd;

	assign tx_din = cmd.want_at ? host_word : sample;

	assign status.state = state;
	assign status.tx_count = tx_count;
	assign status.resp_count = resp_count;
	assign status.tx_full = tx_full;
	assign status.tx_empty = tx_empty;
	assign status.resp_full = resp_full;
	assign status.resp_empty = resp_empty;
	assign status.tx_done = tx_done;
	assign status.rx_done = rx_done;

	sample_source sample_source_i (
		.clock(clock), .reset(reset), .next(sample_next), .sample(sample)
	);

	word_fifo tx_fifo_i (
		.clock(clock), .reset(reset), .wr(tx_wr), .rd(tx_rd), .din(tx_din),
		.dout(tx_dout), .full(tx_full), .empty(tx_empty), .count(tx_count)
	);

	word_fifo resp_fifo_i (
		.clock(clock), .reset(reset), .wr(resp_wr), .rd(resp_rd), .din(rx_word),
		.dout(resp_word), .full(resp_full), .empty(resp_empty), .count(resp_count)
	);

	word_serializer word_serializer_i (
		.clock(clock), .reset(reset), .start(tx_start), .word(tx_dout),
		.tx_done(tx_done), .txd(txd)
	);

	word_deserializer word_deserializer_i (
		.clock(clock), .reset(reset), .arm(rx_arm), .rxd(rxd),
		.rx_done(rx_done), .rx_word(rx_word)
	);

	bt_link_ctrl bt_link_ctrl_i (
		.clock(clock), .reset(reset), .cmd(cmd), .tx_count(tx_count),
		.tx_empty(tx_empty), .tx_done(tx_done), .rx_done(rx_done), .rx_word(rx_word),
		.state(state), .tx_wr(tx_wr), .tx_rd(tx_rd), .tx_start(tx_start),
		.sample_next(sample_next), .rx_arm(rx_arm), .resp_wr(resp_wr),
		.resp_rd(resp_rd), .bt_enable(bt_enable)
	);

endmodule

//--- bt_link_props.sv
`timescale 1ns/10ps
// concurrent checks on the link controller, bound into every bt_link_ctrl
// strobes are sampled on the rising clock edge
module bt_link_props (
	input logic clock,
	input logic reset,
	input bt_host_pkg::host_cmd_t cmd,
	input bt_link_pkg::link_state_t state,
	input logic tx_wr,
	input logic resp_wr,
	input logic tx_start,
	input logic bt_enable
);
	import bt_link_pkg::*;

	int failures = 0;

	assert property (@(posedge clock) $fell(reset) |-> state == idle)
	else
	begin
		failures++;
		$error("state is not idle when reset is released");
	end

	assert property (@(posedge clock) bt_enable == !cmd.want_at)
	else
	begin
		failures++;
		$error("bt_enable does not follow the inverse of want_at");
	end

	assert property (@(posedge clock) !(tx_wr && resp_wr))
	else
	begin
		failures++;
		$error("transmit and response FIFO writes overlap");
	end

	assert property (@(posedge clock) tx_start |-> state == begin_tx)
	else
	begin
		failures++;
		$error("tx_start is high outside begin_tx");
	end

endmodule

bind bt_link_ctrl bt_link_props bt_link_props_i (
	.clock(clock), .reset(reset), .cmd(cmd), .state(state), .tx_wr(tx_wr),
	.resp_wr(resp_wr), .tx_start(tx_start), .bt_enable(bt_enable)
);

//--- tb_bt_link.sv
`timescale 1ns/10ps
// testbench for the radio link controller
// needs a simulator with timing support
// inputs change on the falling clock edge and outputs are checked there as well
// the line model assumes BIT_CYCLES is even and that replies arrive while armed
module tb_bt_link;
	import bt_link_pkg::*;
	import bt_host_pkg::*;

	localparam int WAIT_LIMIT = 200; // clocks allowed per wait

	logic clock;
	logic reset;
	host_cmd_t cmd;
	logic [WORD_W-1:0] host_word;
	logic rxd;
	logic txd;
	logic bt_enable;
	link_status_t status;
	logic [WORD_W-1:0] resp_word;

	int checks;
	int mismatches;
	int timeouts;
	int seed;
	logic [WORD_W-1:0] user_words [4];
	logic [WORD_W-1:0] reply_words [4];
	logic [WORD_W-1:0] line_word;

	bt_link_top bt_link_top_i (
		.clock(clock), .reset(reset), .cmd(cmd), .host_word(host_word), .rxd(rxd),
		.txd(txd), .bt_enable(bt_enable), .status(status), .resp_word(resp_word)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic check_value(input string name, input logic [WORD_W-1:0] expected,
		input logic [WORD_W-1:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			mismatches++;
			$display("mismatch %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic wait_state(input link_state_t target);
		int n;
		link_state_t seen;
		n = 0;
		@(negedge clock);
		while (status.state != target && n < WAIT_LIMIT)
		begin
			@(negedge clock);
			n++;
		end
		seen = status.state;
		if (seen != target)
		begin
			timeouts++;
			$display("timeout waiting for state %s, FSM stuck in %s",
				target.name(), seen.name());
		end
	endtask

	// decodes one character on txd, sampling each bit near its middle
	task automatic receive_txd_frame(output logic [WORD_W-1:0] word);
		int n;
		n = 0;
		word = '0;
		@(negedge clock);
		while (txd !== 1'b0 && n < WAIT_LIMIT)
		begin
			@(negedge clock);
			n++;
		end
		if (txd !== 1'b0)
		begin
			timeouts++;
			$display("timeout waiting for a start bit on txd");
		end
		else
		begin
			repeat (BIT_CYCLES / 2 - 1) @(negedge clock);
			check_value("txd start bit", WORD_W'(1'b0), WORD_W'(txd));
			for (int i = 0; i < WORD_W; i++)
			begin
				repeat (BIT_CYCLES) @(negedge clock);
				word[i] = txd; // lsb first
			end
			repeat (BIT_CYCLES) @(negedge clock);
			check_value("txd stop bit", WORD_W'(1'b1), WORD_W'(txd));
		end
	endtask

	task automatic send_rxd_frame(input logic [WORD_W-1:0] word);
		logic [FRAME_BITS-1:0] frame;
		frame = {1'b1, word, 1'b0};
		for (int i = 0; i < FRAME_BITS; i++)
		begin
			rxd = frame[i];
			repeat (BIT_CYCLES) @(negedge clock);
		end
		repeat (2 * BIT_CYCLES) @(negedge clock); // idle gap between replies
	endtask

	initial
	begin
		int idx;
		int conn;
		int prop_failures;
		checks = 0;
		mismatches = 0;
		timeouts = 0;
		seed = 32'h9b93_2ba6;
		reset = 1'b1;
		cmd = '0;
		host_word = '0;
		rxd = 1'b1;
		for (idx = 0; idx < 4; idx++)
			user_words[idx] = WORD_W'($random(seed));
		for (idx = 0; idx < 3; idx++)
			reply_words[idx] = WORD_W'($random(seed));
		reply_words[3] = AT_END;
		repeat (3) @(negedge clock);
		reset = 1'b0;

		@(negedge clock);
		check_value("state", WORD_W'(idle), WORD_W'(status.state));
		check_value("tx_empty", WORD_W'(1'b1), WORD_W'(status.tx_empty));
		check_value("resp_empty", WORD_W'(1'b1), WORD_W'(status.resp_empty));
		check_value("tx_full", WORD_W'(1'b0), WORD_W'(status.tx_full));
		check_value("resp_full", WORD_W'(1'b0), WORD_W'(status.resp_full));
		check_value("tx_count", WORD_W'(0), WORD_W'(status.tx_count));
		check_value("resp_count", WORD_W'(0), WORD_W'(status.resp_count));
		check_value("tx_done", WORD_W'(1'b0), WORD_W'(status.tx_done));
		check_value("rx_done", WORD_W'(1'b0), WORD_W'(status.rx_done));
		check_value("txd", WORD_W'(1'b1), WORD_W'(txd));
		check_value("bt_enable", WORD_W'(1'b1), WORD_W'(bt_enable));
		cmd.want_at = 1'b1;
		@(negedge clock);
		check_value("bt_enable", WORD_W'(1'b0), WORD_W'(bt_enable));

		// command mode, host words out on txd
		cmd.begin_connection = 1'b1;
		wait_state(wait_user_data);
		for (idx = 0; idx < 4; idx++)
		begin
			host_word = user_words[idx];
			cmd.user_data_loaded = 1'b1;
			wait_state(load_t_user);
			cmd.user_data_loaded = 1'b0;
			if (idx == 3)
				cmd.user_data_done = 1'b1;
			else
				wait_state(wait_user_data);
		end
		wait_state(load_tx);
		cmd.user_data_done = 1'b0;
		check_value("tx_count", WORD_W'(4), WORD_W'(status.tx_count));
		for (idx = 0; idx < 4; idx++)
		begin
			receive_txd_frame(line_word);
			check_value("txd word", user_words[idx], line_word);
		end
		wait_state(receive_resp);
		check_value("tx_empty", WORD_W'(1'b1), WORD_W'(status.tx_empty));

		// reply frames, then read back through the response FIFO
		for (idx = 0; idx < 4; idx++)
			send_rxd_frame(reply_words[idx]);
		wait_state(wait_user_demand);
		check_value("resp_count", WORD_W'(4), WORD_W'(status.resp_count));
		for (idx = 0; idx < 4; idx++)
		begin
			cmd.resp_access = 1'b1;
			wait_state(read_resp);
			cmd.resp_access = 1'b0;
			wait_state(rest_resp_user);
			check_value("resp_word", reply_words[idx], resp_word);
			if (idx == 3)
				cmd.resp_finished = 1'b1;
			else
				wait_state(wait_user_demand);
		end
		wait_state(done);
		cmd.resp_finished = 1'b0;
		check_value("resp_empty", WORD_W'(1'b1), WORD_W'(status.resp_empty));

		repeat (4)
		begin
			@(negedge clock);
			check_value("state", WORD_W'(done), WORD_W'(status.state)); // held by begin_connection
		end
		cmd.begin_connection = 1'b0;
		wait_state(idle);

		// data mode, two bursts from the sensor
		cmd.want_at = 1'b0;
		for (conn = 0; conn < 2; conn++)
		begin
			cmd.begin_connection = 1'b1;
			wait_state(load_t_sample);
			check_value("bt_enable", WORD_W'(1'b1), WORD_W'(bt_enable));
			for (idx = 0; idx < SENSOR_BURST; idx++)
			begin
				receive_txd_frame(line_word);
				check_value("txd sample", SENSOR_BASE + WORD_W'(conn * SENSOR_BURST + idx),
					line_word);
			end
			wait_state(done); // a reply phase would stall in receive_resp
			check_value("tx_empty", WORD_W'(1'b1), WORD_W'(status.tx_empty));
			cmd.begin_connection = 1'b0;
			wait_state(idle);
		end

		prop_failures = bt_link_top_i.bt_link_ctrl_i.bt_link_props_i.failures;
		$display("%0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
			checks, mismatches, timeouts, prop_failures);
		if (mismatches == 0 && timeouts == 0 && prop_failures == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- filelist.f
bt_link_pkg.sv
bt_host_pkg.sv
word_fifo.sv
word_serializer.sv
word_deserializer.sv
sample_source.sv
bt_link_ctrl.sv
bt_link_top.sv
bt_link_props.sv
tb_bt_link.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_bt_link -f filelist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_bt_link)
sim_status=$?
echo "$output"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
	exit 0
fi
exit 1
